// ==== bench/tb_exec_stage.sv ====
//--------------------------------------------------
// Testbench for the execute stage. Random stimulus
// from seed 86 is checked against a local model
// Each instruction is held until the stage takes it
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_exec_stage;

    import exec_width_pkg::*;
    import exec_op_pkg::*;

    localparam int N_ALU      = 200;
    localparam int N_BRANCH   = 100;
    localparam int N_JUMP     = 60;
    localparam int N_TRAP     = 40;
    localparam int N_STALL    = 200;               // Mixed kinds under back-pressure
    localparam int N_TOTAL    = N_ALU + N_BRANCH + N_JUMP + N_TRAP + N_STALL + 1;
    localparam int MAX_CYCLES = N_TOTAL * 20;      // Generous per-instruction budget

    logic       g_clk = 1'b0;
    logic       g_resetn;
    logic       s2_valid;
    logic       s2_flush;
    exec_ctrl_t s2_ctrl;
    exec_opnd_t s2_opnd;
    logic       cf_ack;
    logic       s3_ready;
    logic       s2_ready;
    logic       cf_valid;
    xword_t     cf_target;
    logic       s3_valid;
    logic       s3_full;
    wb_stage_t  s3_out;

    integer     seed;
    int         cycles   = 0;
    int         errors   = 0;
    int         n_checks = 0;
    int         n_tests  = 0;
    int         issued   = 0;                      // Accepted by the stage
    int         retired  = 0;                      // Seen in writeback
    string      test_name;
    logic       stall_mode;                        // Withhold s3_ready and cf_ack
    logic       entry_due;                         // New s3 entry expected
    logic       have_held;                         // s3 holds a checked entry
    wb_stage_t  held;                              // Entry s3 must keep
    wb_stage_t  exp_q[$];

    always #5 g_clk = ~g_clk;

    exec_stage UUT (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .s2_valid  (s2_valid),
        .s2_flush  (s2_flush),
        .s2_ctrl   (s2_ctrl),
        .s2_opnd   (s2_opnd),
        .cf_ack    (cf_ack),
        .s3_ready  (s3_ready),
        .s2_ready  (s2_ready),
        .cf_valid  (cf_valid),
        .cf_target (cf_target),
        .s3_valid  (s3_valid),
        .s3_full   (s3_full),
        .s3_out    (s3_out)
    );

    // Hang guard
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, stage stopped accepting in %s", cycles,
                     test_name);
            $display("Verification failed");
            $finish;
        end
    end

    //--------------------------------------------------
    // Reference model
    //--------------------------------------------------
    function automatic xword_t alu_model(input alu_op_t op, input xword_t a, input xword_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];   // Sign fill
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input cfu_op_t op, input xword_t a, input xword_t b);
        case (op)
            CFU_BEQ:  return a == b;
            CFU_BNE:  return a != b;
            CFU_BLT:  return $signed(a) < $signed(b);
            CFU_BGE:  return $signed(a) >= $signed(b);
            CFU_BLTU: return a < b;
            CFU_BGEU: return a >= b;
            CFU_JAL,
            CFU_JALR: return 1'b1;
            default:  return 1'b0;                 // none, ecall, ebreak
        endcase
    endfunction

    //--------------------------------------------------
    // Compare tasks
    //--------------------------------------------------
    task check_word(input string name, input xword_t want, input xword_t got);
        n_checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, want, got);
        end
    endtask

    task check_reg(input string name, input reg_addr_t want, input reg_addr_t got);
        n_checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s expected %0d actual %0d", name, want, got);
        end
    endtask

    task check_bit(input string name, input logic want, input logic got);
        n_checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch %s expected %b actual %b", name, want, got);
        end
    endtask

    //--------------------------------------------------
    // Stimulus
    //--------------------------------------------------
    task drive_handshake;
        logic [31:0] r;
        r = $random(seed);
        if (stall_mode) begin
            s3_ready <= r[0] | r[1];               // Ready 3 cycles in 4
            cf_ack   <= r[2];
        end else begin
            s3_ready <= 1'b1;
            cf_ack   <= 1'b1;
        end
    endtask

    // Kind 0 ALU, 1 branch, 2 jump, 3 trap, 4 any of these
    task make_instr(input int kind, output exec_ctrl_t c, output exec_opnd_t o);
        logic [31:0] r;
        logic [31:0] s;
        int          k;
        r = $random(seed);
        s = $random(seed);
        k = (kind == 4) ? int'(s[9:8]) : kind;
        o.lhs = $random(seed);
        o.rhs = (r[1:0] == 2'd0) ? o.lhs : $random(seed);   // Equal operands now and then
        o.imm = {{20{r[31]}}, r[31:22], 2'b00};              // Word aligned offset
        o.pc  = $random(seed) & 32'hffff_fffc;
        o.npc = o.pc + 32'd4;
        c.alu_op = alu_op_t'(r[7:4] % 4'd10);
        c.cfu_op = CFU_NONE;
        c.wb_sel = WB_ALU;
        c.rd     = r[12:8];
        case (k)
            1: c.cfu_op = cfu_op_t'(4'd1 + s[3:0] % 4'd6);   // beq through bgeu
            2: begin
                c.cfu_op = s[0] ? CFU_JALR : CFU_JAL;
                c.wb_sel = WB_NPC;
                o.lhs    = o.lhs & 32'hffff_fffd;  // Bit 0 left for jalr to clear
            end
            3: begin
                c.cfu_op = s[1] ? (s[0] ? CFU_JALR : CFU_JAL) :
                                  (s[0] ? CFU_EBREAK : CFU_ECALL);
                c.wb_sel = s[1] ? WB_NPC : WB_ALU;
                o.lhs    = o.lhs & 32'hffff_fffc;
                o.imm    = o.imm | 32'd2;          // Jump target lands on bit 1
            end
            default: ;
        endcase
    endtask

    // Compares a new entry once, then checks that s3 keeps it
    task check_entry;
        if (entry_due) begin
            entry_due = 1'b0;
            held      = exp_q.pop_front();
            have_held = 1'b1;
            check_bit({test_name, " s3_full"}, 1'b1, s3_full);
            check_word({test_name, " pc"}, held.pc, s3_out.pc);
            check_word({test_name, " wdata"}, held.wdata, s3_out.wdata);
            check_reg({test_name, " rd"}, held.rd, s3_out.rd);
            check_bit({test_name, " trap"}, held.trap, s3_out.trap);
            retired++;
        end else if (have_held) begin
            check_bit({test_name, " held s3_full"}, 1'b1, s3_full);
            check_word({test_name, " held pc"}, held.pc, s3_out.pc);
            check_word({test_name, " held wdata"}, held.wdata, s3_out.wdata);
            check_reg({test_name, " held rd"}, held.rd, s3_out.rd);
            check_bit({test_name, " held trap"}, held.trap, s3_out.trap);
        end
    endtask

    task idle_cycle;
        s2_valid <= 1'b0;
        @(negedge g_clk);
        check_entry();
        check_bit({test_name, " idle cf_valid"}, 1'b0, cf_valid);
        check_bit({test_name, " idle s3_valid"}, 1'b0, s3_valid);
        @(posedge g_clk);
        drive_handshake();
    endtask

    // Holds one instruction on decode until the stage takes it
    task issue_instr(input exec_ctrl_t c, input exec_opnd_t o);
        logic      taken;
        logic      misalign;
        logic      req;
        logic      acked;
        logic      accepted;
        xword_t    target;
        wb_stage_t want;
        taken    = branch_taken(c.cfu_op, o.lhs, o.rhs);
        target   = (c.cfu_op == CFU_JALR) ? ((o.lhs + o.imm) & 32'hffff_fffe) : (o.pc + o.imm);
        misalign = taken && target[1];
        req      = taken && !misalign;             // Request goes to fetch
        want.pc    = o.pc;
        want.wdata = (c.wb_sel == WB_NPC) ? o.npc : alu_model(c.alu_op, o.lhs, o.rhs);
        want.trap  = misalign || (c.cfu_op == CFU_ECALL) || (c.cfu_op == CFU_EBREAK);
        if (misalign) want.rd = TRAP_FETCH_MISALIGN;
        else if (c.cfu_op == CFU_EBREAK) want.rd = TRAP_BREAKPOINT;
        else if (c.cfu_op == CFU_ECALL) want.rd = TRAP_ECALL;
        else want.rd = c.rd;
        s2_valid <= 1'b1;
        s2_ctrl  <= c;
        s2_opnd  <= o;
        acked    = 1'b0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge g_clk);
            check_entry();
            check_bit({test_name, " cf_valid"}, req && !acked, cf_valid);
            if (req && !acked) check_word({test_name, " cf_target"}, target, cf_target);
            check_bit({test_name, " s2_ready"}, s3_ready && (!req || acked || cf_ack), s2_ready);
            check_bit({test_name, " s3_valid"}, !req || acked || cf_ack, s3_valid);
            if (req && cf_ack) acked = 1'b1;       // Fetch has the new PC
            accepted = s2_ready;
            if (accepted) begin
                exp_q.push_back(want);
                entry_due = 1'b1;
                issued++;
            end
            @(posedge g_clk);
            drive_handshake();
        end
    endtask

    task report_test(input string name, input int count, input int err_start);
        n_tests++;
        $display("test %-7s %0d instructions, %0d errors", name, count, errors - err_start);
    endtask

    task run_group(input string name, input int kind, input int count, input logic stall);
        exec_ctrl_t c;
        exec_opnd_t o;
        logic [31:0] r;
        int          err_start;
        err_start  = errors;
        test_name  = name;
        stall_mode = stall;
        for (int i = 0; i < count; i++) begin
            make_instr(kind, c, o);
            issue_instr(c, o);
            r = $random(seed);
            if (stall && r[1:0] == 2'd0) idle_cycle();   // Gap in decode output
        end
        idle_cycle();                              // Last entry check
        report_test(name, count, err_start);
    endtask

    task run_flush;
        exec_ctrl_t c;
        exec_opnd_t o;
        int         err_start;
        err_start  = errors;
        test_name  = "flush";
        stall_mode = 1'b0;
        make_instr(3, c, o);
        c.cfu_op = CFU_ECALL;                      // Leaves trap set in s3
        issue_instr(c, o);
        idle_cycle();
        s2_flush  <= 1'b1;
        have_held = 1'b0;
        @(negedge g_clk);
        @(posedge g_clk);
        s2_flush <= 1'b0;
        @(negedge g_clk);
        check_bit("flush s3_full", 1'b0, s3_full);
        check_bit("flush trap", 1'b0, s3_out.trap);
        @(posedge g_clk);
        report_test("flush", 1, err_start);
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial begin : main
        int err_start;
        seed       = 86;
        g_resetn   <= 1'b0;
        s2_valid   <= 1'b0;
        s2_flush   <= 1'b0;
        s2_ctrl    <= '0;
        s2_opnd    <= '0;
        cf_ack     <= 1'b0;
        s3_ready   <= 1'b1;
        stall_mode = 1'b0;
        entry_due  = 1'b0;
        have_held  = 1'b0;
        test_name  = "reset";
        err_start  = errors;
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check_bit("reset s3_full", 1'b0, s3_full);
        check_bit("reset cf_valid", 1'b0, cf_valid);
        @(posedge g_clk);
        report_test("reset", 0, err_start);

        run_group("alu", 0, N_ALU, 1'b0);
        run_group("branch", 1, N_BRANCH, 1'b0);
        run_group("jump", 2, N_JUMP, 1'b0);
        run_group("trap", 3, N_TRAP, 1'b0);
        run_group("stall", 4, N_STALL, 1'b1);
        run_flush();

        if (issued != retired || exp_q.size() != 0) begin
            errors++;
            $display("writeback lost entries, %0d accepted but %0d seen", issued, retired);
        end
        $display("tests %0d, checks %0d, errors %0d, cycles %0d", n_tests, n_checks, errors,
                 cycles);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/exec_width_pkg.sv
verilog/exec_op_pkg.sv
verilog/exec_alu.sv
verilog/exec_cfu.sv
verilog/exec_wb_reg.sv
verilog/exec_stage.sv
bench/tb_exec_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the execute stage testbench with Verilator.
# Exit status is 0 only when the run prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_exec_stage -Mdir obj_dir -o sim_exec
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/sim_exec)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// ==== verilog/exec_alu.sv ====
//--------------------------------------------------
// Integer ALU, purely combinational
// Shift amount is rhs[4:0]. Compare flags are valid
// for every op so branches need no ALU op setting
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module exec_alu (
    input  wire  exec_width_pkg::xword_t lhs,      // Operand A
    input  wire  exec_width_pkg::xword_t rhs,      // Operand B
    input  wire  exec_op_pkg::alu_op_t   op,       // Operation select
    output       exec_width_pkg::xword_t result,   // Operation result
    output logic                         cmp_eq,   // lhs == rhs
    output logic                         cmp_lt,   // lhs <  rhs signed
    output logic                         cmp_ltu   // lhs <  rhs unsigned
);

    import exec_width_pkg::*;
    import exec_op_pkg::*;

    logic              do_sub;                     // Adder in subtract mode
    xword_t            addsub_out;
    shamt_t            shamt;
    logic              shift_left;
    logic              shift_fill;                 // Sign bit for sra
    xword_t            shift_in;
    logic [2*XLEN-1:0] shift_ext;
    xword_t            shift_raw;
    xword_t            shift_out;

    //--------------------------------------------------
    // Adder and compare
    //--------------------------------------------------
    assign do_sub     = (op == ALU_SUB);
    assign addsub_out = lhs + (do_sub ? ~rhs : rhs) + {{(XLEN-1){1'b0}}, do_sub};

    assign cmp_eq  = (lhs == rhs);
    assign cmp_ltu = (lhs < rhs);
    assign cmp_lt  = (lhs[XLEN-1] != rhs[XLEN-1]) ? lhs[XLEN-1] : cmp_ltu; // Signs differ

    //--------------------------------------------------
    // Barrel shifter, right only
    //--------------------------------------------------
    assign shamt      = rhs[SHAMT_W-1:0];
    assign shift_left = (op == ALU_SLL);
    assign shift_fill = (op == ALU_SRA) && lhs[XLEN-1];

    // Left shift done by reversing around the right shifter
    always_comb begin : shift_in_rev
        for (int i = 0; i < XLEN; i++) begin
            shift_in[i] = shift_left ? lhs[XLEN-1-i] : lhs[i];
        end
    end

    assign shift_ext = {{XLEN{shift_fill}}, shift_in} >> shamt;  // Fill from top
    assign shift_raw = shift_ext[XLEN-1:0];

    always_comb begin : shift_out_rev
        for (int i = 0; i < XLEN; i++) begin
            shift_out[i] = shift_left ? shift_raw[XLEN-1-i] : shift_raw[i];
        end
    end

    //--------------------------------------------------
    // Result select
    //--------------------------------------------------
    always_comb begin
        case (op)
            ALU_ADD,
            ALU_SUB:  result = addsub_out;
            ALU_AND:  result = lhs & rhs;
            ALU_OR:   result = lhs | rhs;
            ALU_XOR:  result = lhs ^ rhs;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, cmp_lt};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, cmp_ltu};
            ALU_SLL,
            ALU_SRL,
            ALU_SRA:  result = shift_out;
            default:  result = addsub_out;         // Unused encodings
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/exec_cfu.sv ====
//--------------------------------------------------
// Control-flow unit. Resolves branches and jumps,
// raises ecall, ebreak and misaligned fetch traps
// Only bit 1 of the target is checked, since branch
// and jal offsets are even and jalr clears bit 0
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module exec_cfu (
    input  wire  g_clk,
    input  wire  g_resetn,
    input  wire  valid,                                  // Instruction present in stage
    input  wire  accept,                                 // Instruction leaves the stage
    input  wire  exec_op_pkg::cfu_op_t       op,
    input  wire  exec_op_pkg::exec_opnd_t    opnd,
    input  wire  cmp_eq,                                 // From the ALU
    input  wire  cmp_lt,
    input  wire  cmp_ltu,
    input  wire  cf_ack,                                 // Fetch took the request
    output logic cf_valid,                               // Request a PC change
    output       exec_width_pkg::xword_t     cf_target,  // New PC
    output logic finished,                               // Stage may advance
    output logic trap,                                   // Raise a trap
    output       exec_width_pkg::reg_addr_t  trap_cause
);

    import exec_width_pkg::*;
    import exec_op_pkg::*;

    logic   taken;                                 // Branch condition or jump
    logic   is_jalr;
    xword_t target_base;
    xword_t target_sum;
    xword_t target;
    logic   misalign;
    logic   cf_req;                                // Aligned taken change
    logic   done;                                  // Request already acked

    //--------------------------------------------------
    // Condition and target
    //--------------------------------------------------
    always_comb begin
        case (op)
            CFU_BEQ:  taken = cmp_eq;
            CFU_BNE:  taken = !cmp_eq;
            CFU_BLT:  taken = cmp_lt;
            CFU_BGE:  taken = !cmp_lt;
            CFU_BLTU: taken = cmp_ltu;
            CFU_BGEU: taken = !cmp_ltu;
            CFU_JAL,
            CFU_JALR: taken = 1'b1;
            default:  taken = 1'b0;                // none, ecall, ebreak
        endcase
    end

    assign is_jalr     = (op == CFU_JALR);
    assign target_base = is_jalr ? opnd.lhs : opnd.pc;
    assign target_sum  = target_base + opnd.imm;
    assign target      = {target_sum[XLEN-1:1], target_sum[0] && !is_jalr};

    assign misalign = taken && target[1];
    assign cf_req   = valid && taken && !misalign;

    //--------------------------------------------------
    // Request to fetch
    //--------------------------------------------------
    assign cf_valid  = cf_req && !done;
    assign cf_target = target;
    assign finished  = !cf_req || done || cf_ack;  // Ack ends the wait this cycle

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            done <= 1'b0;
        end else if (accept) begin
            done <= 1'b0;                          // Next instruction starts clean
        end else if (cf_valid && cf_ack) begin
            done <= 1'b1;                          // Hold while writeback stalls
        end
    end

    //--------------------------------------------------
    // Traps
    //--------------------------------------------------
    assign trap = misalign || (op == CFU_ECALL) || (op == CFU_EBREAK);

    always_comb begin
        if (misalign) begin
            trap_cause = TRAP_FETCH_MISALIGN;
        end else if (op == CFU_EBREAK) begin
            trap_cause = TRAP_BREAKPOINT;
        end else if (op == CFU_ECALL) begin
            trap_cause = TRAP_ECALL;
        end else begin
            trap_cause = '0;                       // No trap
        end
    end

endmodule

`default_nettype wire

// ==== verilog/exec_op_pkg.sv ====
//--------------------------------------------------
// Operation encodings and stage payload structs
// Decode fills exec_ctrl_t and exec_opnd_t. The
// writeback register carries wb_stage_t onward
//--------------------------------------------------
`default_nettype none

package exec_op_pkg;

    import exec_width_pkg::*;

    //--------------------------------------------------
    // ALU operations
    //--------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,                           // Signed set less than
        ALU_SLTU = 4'd6,                           // Unsigned set less than
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    //--------------------------------------------------
    // Control-flow operations
    //--------------------------------------------------
    typedef enum logic [3:0] {
        CFU_NONE   = 4'd0,                         // ALU only instruction
        CFU_BEQ    = 4'd1,
        CFU_BNE    = 4'd2,
        CFU_BLT    = 4'd3,
        CFU_BGE    = 4'd4,
        CFU_BLTU   = 4'd5,
        CFU_BGEU   = 4'd6,
        CFU_JAL    = 4'd7,
        CFU_JALR   = 4'd8,
        CFU_ECALL  = 4'd9,
        CFU_EBREAK = 4'd10
    } cfu_op_t;

    typedef enum logic {
        WB_ALU = 1'b0,                             // Write ALU result
        WB_NPC = 1'b1                              // Write link address
    } wb_sel_t;

    //--------------------------------------------------
    // Payload structs
    //--------------------------------------------------
    typedef struct packed {
        alu_op_t   alu_op;
        cfu_op_t   cfu_op;
        wb_sel_t   wb_sel;
        reg_addr_t rd;
    } exec_ctrl_t;                                 // 14 bits

    typedef struct packed {
        xword_t lhs;                               // rs1 or operand A
        xword_t rhs;                               // rs2 or operand B
        xword_t imm;
        xword_t pc;                                // Current PC
        xword_t npc;                               // Next sequential PC
    } exec_opnd_t;                                 // 160 bits

    typedef struct packed {
        xword_t    pc;
        xword_t    wdata;
        reg_addr_t rd;                             // Trap cause when trap is set
        logic      trap;
    } wb_stage_t;                                  // 70 bits

endpackage

`default_nettype wire

// ==== verilog/exec_stage.sv ====
//--------------------------------------------------
// Execute stage top. RV32 integer ALU and control
// flow only, no memory, CSR or multiply support
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module exec_stage (
    input  wire  g_clk,
    input  wire  g_resetn,
    input  wire  s2_valid,                               // Decode has an instruction
    input  wire  s2_flush,
    input  wire  exec_op_pkg::exec_ctrl_t  s2_ctrl,
    input  wire  exec_op_pkg::exec_opnd_t  s2_opnd,
    input  wire  cf_ack,
    input  wire  s3_ready,
    output logic s2_ready,
    output logic cf_valid,
    output       exec_width_pkg::xword_t   cf_target,
    output logic s3_valid,
    output logic s3_full,
    output       exec_op_pkg::wb_stage_t   s3_out
);

    import exec_width_pkg::*;

    xword_t    alu_result;
    logic      cmp_eq;
    logic      cmp_lt;
    logic      cmp_ltu;
    logic      cfu_finished;
    logic      cfu_trap;
    reg_addr_t cfu_trap_cause;
    logic      accept;                             // s2 handshake done

    exec_alu u_alu (
        .lhs        (s2_opnd.lhs),
        .rhs        (s2_opnd.rhs),
        .op         (s2_ctrl.alu_op),
        .result     (alu_result),
        .cmp_eq     (cmp_eq),
        .cmp_lt     (cmp_lt),
        .cmp_ltu    (cmp_ltu)
    );

    exec_cfu u_cfu (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .valid      (s2_valid),
        .accept     (accept),
        .op         (s2_ctrl.cfu_op),
        .opnd       (s2_opnd),
        .cmp_eq     (cmp_eq),
        .cmp_lt     (cmp_lt),
        .cmp_ltu    (cmp_ltu),
        .cf_ack     (cf_ack),
        .cf_valid   (cf_valid),
        .cf_target  (cf_target),
        .finished   (cfu_finished),
        .trap       (cfu_trap),
        .trap_cause (cfu_trap_cause)
    );

    exec_wb_reg u_wb_reg (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s2_flush     (s2_flush),
        .s2_valid     (s2_valid),
        .s3_ready     (s3_ready),
        .ctrl         (s2_ctrl),
        .opnd         (s2_opnd),
        .alu_result   (alu_result),
        .cfu_finished (cfu_finished),
        .trap         (cfu_trap),
        .trap_cause   (cfu_trap_cause),
        .s2_ready     (s2_ready),
        .s3_valid     (s3_valid),
        .accept       (accept),
        .s3_full      (s3_full),
        .s3_out       (s3_out)
    );

endmodule

`default_nettype wire

// ==== verilog/exec_wb_reg.sv ====
//--------------------------------------------------
// Stage handshake and writeback pipeline register
// s3_full stays set until a flush or reset. Each
// acceptance loads a new entry into s3_out
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module exec_wb_reg (
    input  wire  g_clk,
    input  wire  g_resetn,
    input  wire  s2_flush,                              // Drop writeback contents
    input  wire  s2_valid,
    input  wire  s3_ready,
    input  wire  exec_op_pkg::exec_ctrl_t   ctrl,
    input  wire  exec_op_pkg::exec_opnd_t   opnd,
    input  wire  exec_width_pkg::xword_t    alu_result,
    input  wire  cfu_finished,
    input  wire  trap,
    input  wire  exec_width_pkg::reg_addr_t trap_cause,
    output logic s2_ready,
    output logic s3_valid,
    output logic accept,                                // Stage advances this cycle
    output logic s3_full,
    output       exec_op_pkg::wb_stage_t    s3_out
);

    import exec_width_pkg::*;
    import exec_op_pkg::*;

    xword_t    n_wdata;
    reg_addr_t n_rd;
    xword_t    pc_q;                               // Payload
    xword_t    wdata_q;
    reg_addr_t rd_q;
    logic      trap_q;

    //--------------------------------------------------
    // Handshake
    //--------------------------------------------------
    assign s2_ready = s3_ready && cfu_finished;
    assign s3_valid = s2_valid && cfu_finished;
    assign accept   = s3_valid && s3_ready;

    //--------------------------------------------------
    // Next entry
    //--------------------------------------------------
    assign n_wdata = (ctrl.wb_sel == WB_NPC) ? opnd.npc : alu_result;
    assign n_rd    = trap ? trap_cause : ctrl.rd;  // rd carries the cause

    always_ff @(posedge g_clk) begin
        if (!g_resetn || s2_flush) begin
            s3_full <= 1'b0;
            trap_q  <= 1'b0;
        end else if (accept) begin
            s3_full <= 1'b1;
            trap_q  <= trap;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            pc_q    <= opnd.pc;
            wdata_q <= n_wdata;
            rd_q    <= n_rd;
        end
    end

    assign s3_out = '{pc: pc_q, wdata: wdata_q, rd: rd_q, trap: trap_q};

endmodule

`default_nettype wire

// ==== verilog/exec_width_pkg.sv ====
//--------------------------------------------------
// Datapath widths for the execute stage
// RV32 only. The widths here are fixed and the RTL
// is not written to follow other values
//--------------------------------------------------
`default_nettype none

package exec_width_pkg;

    localparam int XLEN       = 32;                // Datapath width
    localparam int REG_ADDR_W = 5;                 // Register address width
    localparam int SHAMT_W    = 5;                 // Shift amount width

    //--------------------------------------------------
    // Plain vector types
    //--------------------------------------------------
    typedef logic [XLEN-1:0]       xword_t;        // Data, operands, PCs, immediates
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;     // Destination reg or trap cause
    typedef logic [SHAMT_W-1:0]    shamt_t;        // Shift amount

    //--------------------------------------------------
    // Trap causes, carried in the rd field
    //--------------------------------------------------
    localparam reg_addr_t TRAP_FETCH_MISALIGN = 5'd0;   // Fetch address misaligned
    localparam reg_addr_t TRAP_BREAKPOINT     = 5'd3;   // ebreak
    localparam reg_addr_t TRAP_ECALL          = 5'd11;  // ecall from M-mode

endpackage

`default_nettype wire
